//--- design/rv_config.svh
// rv64i decode stage widths
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path and pc
`define RV_XLEN 64

// one instruction word
`define RV_INST_WD 32

// general purpose registers
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// a0 carries the ebreak exit code
`define RV_REG_A0 5'd10

`endif

//--- design/rv_pkg.sv
// rv64i decode types
package rv_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_XOR = 3'd2,
    ALU_OR  = 3'd3,
    ALU_AND = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_e;

  // conditional codes follow funct3, jumps use the two unused slots
  typedef enum logic [2:0] {
    BR_EQ   = 3'b000,
    BR_NE   = 3'b001,
    BR_JAL  = 3'b010,
    BR_JALR = 3'b011,
    BR_LT   = 3'b100,
    BR_GE   = 3'b101,
    BR_LTU  = 3'b110,
    BR_GEU  = 3'b111
  } br_func_e;

  typedef enum logic [1:0] {
    MEM_NONE   = 2'd0,
    MEM_WORD   = 2'd1,
    MEM_DOUBLE = 2'd2
  } mem_op_e;

  typedef enum logic {
    SRC2_RS2 = 1'b0,
    SRC2_IMM = 1'b1
  } src2_sel_e;

endpackage

//--- design/id_decoder.sv
// instruction decoder
`timescale 1ns/1ps
`include "rv_config.svh"

module id_decoder (
  input  logic [`RV_INST_WD-1:0] i_inst,
  output logic [`RV_REG_AW-1:0]  o_rs1,
  output logic [`RV_REG_AW-1:0]  o_rs2,
  output logic [`RV_REG_AW-1:0]  o_rd,
  output logic [`RV_XLEN-1:0]    o_imm,
  output rv_pkg::alu_op_e        o_alu_op,
  output logic                   o_src1_pc,
  output rv_pkg::src2_sel_e      o_src2_sel,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output rv_pkg::mem_op_e        o_mem_op,
  output logic                   o_bren,
  output rv_pkg::br_func_e       o_br_func,
  output logic                   o_ebreak,
  output logic                   o_invalid
);

  rv_pkg::opcode_e        opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [`RV_XLEN-1:0]    imm_i, imm_s, imm_b, imm_u, imm_j;
  rv_pkg::alu_op_e        f3_alu_op;
  logic                   f3_alu_ok;
  logic                   legal;

  assign opcode = rv_pkg::opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rs2  = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  assign imm_i = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`RV_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  // shared by op-imm and op
  always_comb begin
    f3_alu_ok = 1'b1;
    case (funct3)
      3'b000:  f3_alu_op = rv_pkg::ALU_ADD;
      3'b010:  f3_alu_op = rv_pkg::ALU_SLT;
      3'b100:  f3_alu_op = rv_pkg::ALU_XOR;
      3'b110:  f3_alu_op = rv_pkg::ALU_OR;
      3'b111:  f3_alu_op = rv_pkg::ALU_AND;
      default: begin
        f3_alu_op = rv_pkg::ALU_ADD;
        f3_alu_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    o_rs1      = i_inst[19:15];
    o_imm      = '0;
    o_alu_op   = rv_pkg::ALU_ADD;
    o_src1_pc  = 1'b0;
    o_src2_sel = rv_pkg::SRC2_RS2;
    o_gpr_wen  = 1'b0;
    o_mem_ren  = 1'b0;
    o_mem_wen  = 1'b0;
    o_mem_op   = rv_pkg::MEM_NONE;
    o_bren     = 1'b0;
    o_br_func  = rv_pkg::BR_EQ;
    o_ebreak   = 1'b0;
    o_invalid  = 1'b0;
    legal      = 1'b1;
    case (opcode)
      rv_pkg::OP_LUI: begin
        o_rs1      = '0; // x0 + imm
        o_imm      = imm_u;
        o_src2_sel = rv_pkg::SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      rv_pkg::OP_AUIPC: begin
        o_imm      = imm_u;
        o_src1_pc  = 1'b1;
        o_src2_sel = rv_pkg::SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      rv_pkg::OP_JAL: begin
        o_imm     = imm_j;
        o_src1_pc = 1'b1; // link formed from pc in execute
        o_gpr_wen = 1'b1;
        o_bren    = 1'b1;
        o_br_func = rv_pkg::BR_JAL;
      end
      rv_pkg::OP_JALR: begin
        o_imm     = imm_i;
        o_src1_pc = 1'b1;
        o_gpr_wen = 1'b1;
        o_bren    = 1'b1;
        o_br_func = rv_pkg::BR_JALR;
        legal     = (funct3 == 3'b000);
      end
      rv_pkg::OP_BRANCH: begin
        o_imm     = imm_b;
        o_bren    = 1'b1;
        o_br_func = rv_pkg::br_func_e'(funct3);
        legal     = (funct3[2:1] != 2'b01); // 010/011 are not branches
      end
      rv_pkg::OP_LOAD, rv_pkg::OP_STORE: begin
        o_imm      = (opcode == rv_pkg::OP_LOAD) ? imm_i : imm_s;
        o_src2_sel = rv_pkg::SRC2_IMM;
        o_gpr_wen  = (opcode == rv_pkg::OP_LOAD);
        o_mem_ren  = (opcode == rv_pkg::OP_LOAD);
        o_mem_wen  = (opcode == rv_pkg::OP_STORE);
        o_mem_op   = funct3[0] ? rv_pkg::MEM_DOUBLE : rv_pkg::MEM_WORD;
        legal      = (funct3[2:1] == 2'b01); // lw/ld, sw/sd only
      end
      rv_pkg::OP_IMM: begin
        o_imm      = imm_i;
        o_src2_sel = rv_pkg::SRC2_IMM;
        o_alu_op   = f3_alu_op;
        o_gpr_wen  = 1'b1;
        legal      = f3_alu_ok;
      end
      rv_pkg::OP_REG: begin
        o_gpr_wen = 1'b1;
        if (funct7 == 7'b0000000) begin
          o_alu_op = f3_alu_op;
          legal    = f3_alu_ok;
        end else begin
          o_alu_op = rv_pkg::ALU_SUB;
          legal    = (funct7 == 7'b0100000) && (funct3 == 3'b000);
        end
      end
      rv_pkg::OP_SYSTEM: begin
        o_ebreak = 1'b1;
        legal    = (i_inst == 32'h0010_0073);
      end
      default: legal = 1'b0;
    endcase
    // anything outside the subset leaves as a bubble
    if (!legal) begin
      o_gpr_wen = 1'b0;
      o_mem_ren = 1'b0;
      o_mem_wen = 1'b0;
      o_mem_op  = rv_pkg::MEM_NONE;
      o_bren    = 1'b0;
      o_ebreak  = 1'b0;
      o_invalid = (i_inst != '0); // all-zero word is a plain bubble
    end
  end

endmodule

//--- design/gpr_file.sv
// general purpose register file
`timescale 1ns/1ps
`include "rv_config.svh"

module gpr_file (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic [`RV_REG_AW-1:0] i_raddr1,
  input  logic [`RV_REG_AW-1:0] i_raddr2,
  output logic [`RV_XLEN-1:0]   o_rdata1,
  output logic [`RV_XLEN-1:0]   o_rdata2,
  input  logic                  i_wen,
  input  logic [`RV_REG_AW-1:0] i_waddr,
  input  logic [`RV_XLEN-1:0]   i_wdata
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin // x0 stays zero
      regs[i_waddr] <= i_wdata;
    end
  end

  // no internal write-through, bypass covers the same cycle
  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

endmodule

//--- design/operand_bypass.sv
// source operand forwarding
`timescale 1ns/1ps
`include "rv_config.svh"

module operand_bypass (
  input  logic [`RV_REG_AW-1:0] i_rs1,
  input  logic [`RV_REG_AW-1:0] i_rs2,
  input  logic [`RV_XLEN-1:0]   i_rf_rdata1,
  input  logic [`RV_XLEN-1:0]   i_rf_rdata2,
  input  logic [`RV_REG_AW-1:0] i_es_gpr_rd,
  input  logic [`RV_XLEN-1:0]   i_es_gpr_result,
  input  logic [`RV_REG_AW-1:0] i_ms_gpr_rd,
  input  logic [`RV_XLEN-1:0]   i_ms_gpr_result,
  input  logic [`RV_REG_AW-1:0] i_ws_gpr_rd,
  input  logic [`RV_XLEN-1:0]   i_ws_gpr_result,
  output logic [`RV_XLEN-1:0]   o_rs1data,
  output logic [`RV_XLEN-1:0]   o_rs2data
);

  // youngest producer wins
  function automatic logic [`RV_XLEN-1:0] pick(input logic [`RV_REG_AW-1:0] rs,
                                               input logic [`RV_XLEN-1:0]   rf_data);
    if ((i_es_gpr_rd != '0) && (i_es_gpr_rd == rs)) begin
      return i_es_gpr_result;
    end
    if ((i_ms_gpr_rd != '0) && (i_ms_gpr_rd == rs)) begin
      return i_ms_gpr_result;
    end
    if ((i_ws_gpr_rd != '0) && (i_ws_gpr_rd == rs)) begin
      return i_ws_gpr_result;
    end
    return rf_data;
  endfunction

  always_comb begin
    o_rs1data = pick(i_rs1, i_rf_rdata1);
    o_rs2data = pick(i_rs2, i_rf_rdata2);
  end

endmodule

//--- design/branch_unit.sv
// branch and jump resolution
`timescale 1ns/1ps
`include "rv_config.svh"

module branch_unit (
  input  logic                 i_bren,
  input  rv_pkg::br_func_e     i_br_func,
  input  logic [`RV_XLEN-1:0]  i_pc,
  input  logic [`RV_XLEN-1:0]  i_rs1data,
  input  logic [`RV_XLEN-1:0]  i_rs2data,
  input  logic [`RV_XLEN-1:0]  i_imm,
  output logic                 o_br_sel,
  output logic [`RV_XLEN-1:0]  o_br_target
);

  logic                cond;
  logic [`RV_XLEN-1:0] pc_target;
  logic [`RV_XLEN-1:0] jalr_sum;

  always_comb begin
    case (i_br_func)
      rv_pkg::BR_EQ:  cond = (i_rs1data == i_rs2data);
      rv_pkg::BR_NE:  cond = (i_rs1data != i_rs2data);
      rv_pkg::BR_LT:  cond = ($signed(i_rs1data) <  $signed(i_rs2data));
      rv_pkg::BR_GE:  cond = ($signed(i_rs1data) >= $signed(i_rs2data));
      rv_pkg::BR_LTU: cond = (i_rs1data <  i_rs2data);
      rv_pkg::BR_GEU: cond = (i_rs1data >= i_rs2data);
      default:        cond = 1'b1; // jal, jalr always redirect
    endcase
  end

  assign pc_target = i_pc + i_imm;
  assign jalr_sum  = i_rs1data + i_imm;

  // jalr drops bit 0 of the sum
  assign o_br_target = (i_br_func == rv_pkg::BR_JALR) ?
                       {jalr_sum[`RV_XLEN-1:1], 1'b0} : pc_target;

  assign o_br_sel = i_bren && cond;

endmodule

//--- design/id_stage.sv
// rv64i instruction decode stage
`timescale 1ns/1ps
`include "rv_config.svh"

module id_stage (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_es_allowin,
  output logic                   o_ds_allowin,
  input  logic                   i_fs_to_ds_valid,
  input  logic [`RV_INST_WD-1:0] i_fs_inst,
  input  logic [`RV_XLEN-1:0]    i_fs_pc,
  output logic                   o_ds_to_es_valid,
  input  logic                   i_ws_gpr_wen,
  input  logic [`RV_REG_AW-1:0]  i_ws_gpr_waddr,
  input  logic [`RV_XLEN-1:0]    i_ws_gpr_wdata,
  input  logic [`RV_REG_AW-1:0]  i_es_gpr_rd,
  input  logic [`RV_XLEN-1:0]    i_es_gpr_result,
  input  logic [`RV_REG_AW-1:0]  i_ms_gpr_rd,
  input  logic [`RV_XLEN-1:0]    i_ms_gpr_result,
  input  logic [`RV_REG_AW-1:0]  i_ws_gpr_rd,
  input  logic [`RV_XLEN-1:0]    i_ws_gpr_result,
  output logic [`RV_XLEN-1:0]    o_ds_pc,
  output logic [`RV_XLEN-1:0]    o_ds_rs1data,
  output logic [`RV_XLEN-1:0]    o_ds_rs2data,
  output logic [`RV_XLEN-1:0]    o_ds_imm,
  output logic [`RV_REG_AW-1:0]  o_ds_rd,
  output rv_pkg::alu_op_e        o_ds_alu_op,
  output logic                   o_ds_src1_pc,
  output rv_pkg::src2_sel_e      o_ds_src2_sel,
  output logic                   o_ds_gpr_wen,
  output logic                   o_ds_mem_ren,
  output logic                   o_ds_mem_wen,
  output rv_pkg::mem_op_e        o_ds_mem_op,
  output logic                   o_ds_ebreak,
  output logic                   o_ds_invalid,
  output logic                   o_br_sel,
  output logic                   o_br_taken,
  output logic [`RV_XLEN-1:0]    o_br_target
);

  logic                   ds_valid;
  logic                   ds_ready_go;
  logic                   ebreak_wait;
  logic [`RV_INST_WD-1:0] ds_inst;
  logic [`RV_REG_AW-1:0]  rs1, rs2;
  logic [`RV_XLEN-1:0]    rf_rdata1, rf_rdata2;
  logic                   dec_bren;
  rv_pkg::br_func_e       dec_br_func;

  // ebreak waits until no later stage still owes a0
  assign ebreak_wait = o_ds_ebreak && ((i_es_gpr_rd == `RV_REG_A0) ||
                                       (i_ms_gpr_rd == `RV_REG_A0) ||
                                       (i_ws_gpr_rd == `RV_REG_A0));

  assign ds_ready_go      = !ebreak_wait;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_inst <= '0;
      o_ds_pc <= '0;
    end else if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_inst <= o_br_taken ? '0 : i_fs_inst; // wrong-path slot becomes a bubble
      o_ds_pc <= o_br_taken ? '0 : i_fs_pc;
    end
  end

  assign o_br_taken = o_br_sel && (o_br_target != i_fs_pc);

  id_decoder u_decoder (
    .i_inst     (ds_inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (o_ds_rd),
    .o_imm      (o_ds_imm),
    .o_alu_op   (o_ds_alu_op),
    .o_src1_pc  (o_ds_src1_pc),
    .o_src2_sel (o_ds_src2_sel),
    .o_gpr_wen  (o_ds_gpr_wen),
    .o_mem_ren  (o_ds_mem_ren),
    .o_mem_wen  (o_ds_mem_wen),
    .o_mem_op   (o_ds_mem_op),
    .o_bren     (dec_bren),
    .o_br_func  (dec_br_func),
    .o_ebreak   (o_ds_ebreak),
    .o_invalid  (o_ds_invalid)
  );

  gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2),
    .i_wen    (i_ws_gpr_wen),
    .i_waddr  (i_ws_gpr_waddr),
    .i_wdata  (i_ws_gpr_wdata)
  );

  operand_bypass u_bypass (
    .i_rs1           (rs1),
    .i_rs2           (rs2),
    .i_rf_rdata1     (rf_rdata1),
    .i_rf_rdata2     (rf_rdata2),
    .i_es_gpr_rd     (i_es_gpr_rd),
    .i_es_gpr_result (i_es_gpr_result),
    .i_ms_gpr_rd     (i_ms_gpr_rd),
    .i_ms_gpr_result (i_ms_gpr_result),
    .i_ws_gpr_rd     (i_ws_gpr_rd),
    .i_ws_gpr_result (i_ws_gpr_result),
    .o_rs1data       (o_ds_rs1data),
    .o_rs2data       (o_ds_rs2data)
  );

  // a stale instruction left behind an empty slot must not redirect fetch
  branch_unit u_bru (
    .i_bren      (ds_valid && dec_bren),
    .i_br_func   (dec_br_func),
    .i_pc        (o_ds_pc),
    .i_rs1data   (o_ds_rs1data),
    .i_rs2data   (o_ds_rs2data),
    .i_imm       (o_ds_imm),
    .o_br_sel    (o_br_sel),
    .o_br_target (o_br_target)
  );

endmodule

//--- verif/id_stage_checker.sv
// decode stage assertions
`timescale 1ns/1ps
`include "rv_config.svh"

module id_stage_checker (
  input logic                  i_clk,
  input logic                  i_rst_n,
  input logic                  i_es_allowin,
  input logic                  o_ds_to_es_valid,
  input logic                  o_ds_ebreak,
  input logic                  o_br_sel,
  input logic                  o_br_taken,
  input logic [`RV_REG_AW-1:0] i_es_gpr_rd,
  input logic [`RV_REG_AW-1:0] i_ms_gpr_rd,
  input logic [`RV_REG_AW-1:0] i_ws_gpr_rd,
  input logic [`RV_XLEN-1:0]   o_ds_pc
);

  logic a0_pending;

  assign a0_pending = (i_es_gpr_rd == `RV_REG_A0) || (i_ms_gpr_rd == `RV_REG_A0) ||
                      (i_ws_gpr_rd == `RV_REG_A0);

  taken_needs_sel: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_br_taken |-> o_br_sel) else $error("br_taken without br_sel");

  ebreak_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_ds_to_es_valid |-> !(o_ds_ebreak && a0_pending)) else $error("ebreak passed with a0 pending");

  empty_after_reset: assert property (@(posedge i_clk)
    $rose(i_rst_n) |-> !o_ds_to_es_valid) else $error("valid right after reset");

  hold_on_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_to_es_valid && !i_es_allowin) |=> ($stable(o_ds_pc) && o_ds_to_es_valid))
    else $error("stage changed under back-pressure");

endmodule

bind id_stage id_stage_checker u_checker (.*);

//--- verif/id_stage_tb.sv
// decode stage testbench
`timescale 1ns/1ps
`include "rv_config.svh"

module id_stage_tb;

  localparam int TIMEOUT_CYCLES = 2000;

  logic clk, rst_n, es_allowin, fs_valid, ws_wen;
  logic [31:0] fs_inst;
  logic [63:0] fs_pc, ws_wdata, es_res, ms_res, ws_res;
  logic [4:0] ws_waddr, es_rd, ms_rd, ws_rd;
  logic ds_allowin, ds_valid, src1_pc, gpr_wen, mem_ren, mem_wen, ebreak, invalid;
  logic br_sel, br_taken;
  logic [63:0] ds_pc, rs1data, rs2data, imm, br_target;
  logic [4:0] rd;
  rv_pkg::alu_op_e alu_op;
  rv_pkg::src2_sel_e src2_sel;
  rv_pkg::mem_op_e mem_op;

  logic [63:0] model [32];
  logic [31:0] lcg_state = 32'd43;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  id_stage uut (
    .i_clk(clk), .i_rst_n(rst_n), .i_es_allowin(es_allowin), .o_ds_allowin(ds_allowin),
    .i_fs_to_ds_valid(fs_valid), .i_fs_inst(fs_inst), .i_fs_pc(fs_pc),
    .o_ds_to_es_valid(ds_valid), .i_ws_gpr_wen(ws_wen), .i_ws_gpr_waddr(ws_waddr),
    .i_ws_gpr_wdata(ws_wdata), .i_es_gpr_rd(es_rd), .i_es_gpr_result(es_res),
    .i_ms_gpr_rd(ms_rd), .i_ms_gpr_result(ms_res), .i_ws_gpr_rd(ws_rd),
    .i_ws_gpr_result(ws_res), .o_ds_pc(ds_pc), .o_ds_rs1data(rs1data),
    .o_ds_rs2data(rs2data), .o_ds_imm(imm), .o_ds_rd(rd), .o_ds_alu_op(alu_op),
    .o_ds_src1_pc(src1_pc), .o_ds_src2_sel(src2_sel), .o_ds_gpr_wen(gpr_wen),
    .o_ds_mem_ren(mem_ren), .o_ds_mem_wen(mem_wen), .o_ds_mem_op(mem_op),
    .o_ds_ebreak(ebreak), .o_ds_invalid(invalid), .o_br_sel(br_sel),
    .o_br_taken(br_taken), .o_br_target(br_target)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] i, logic [4:0] s1, logic [2:0] f3,
                                        logic [4:0] d, logic [6:0] op);
    return {i, s1, f3, d, op};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] s2, logic [4:0] s1,
                                        logic [2:0] f3, logic [4:0] d);
    return {f7, s2, s1, f3, d, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] i, logic [4:0] s2, logic [4:0] s1);
    return {i[11:5], s2, s1, 3'b011, i[4:0], 7'b0100011}; // sd
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] i, logic [4:0] s2, logic [4:0] s1,
                                        logic [2:0] f3);
    return {i[12], i[10:5], s2, s1, f3, i[4:1], i[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] i, logic [4:0] d);
    return {i[20], i[10:1], i[11], i[19:12], d, 7'b1101111};
  endfunction

  function automatic logic [63:0] reg_val(logic [4:0] idx);
    return (idx == 5'd0) ? 64'd0 : model[idx];
  endfunction

  function automatic logic branch_holds(logic [2:0] f3, logic [63:0] a, logic [63:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic write_reg(input logic [4:0] idx, input logic [63:0] val);
    @(negedge clk);
    ws_wen = 1'b1;
    ws_waddr = idx;
    ws_wdata = val;
    @(negedge clk);
    ws_wen = 1'b0;
    if (idx != 5'd0) model[idx] = val;
  endtask

  // returns at the falling edge after the stage took the word
  task automatic send(input logic [31:0] inst, input logic [63:0] pc);
    @(negedge clk);
    fs_valid = 1'b1;
    fs_inst = inst;
    fs_pc = pc;
    #1;
    while (!ds_allowin) @(negedge clk);
    @(negedge clk);
    fs_valid = 1'b0;
    #1;
  endtask

  // src1 is never the pc for these words
  task automatic check_ctrl(input logic [2:0] a, input logic s2, input logic w,
                            input logic mr, input logic mw, input logic [1:0] mo);
    check_val(64'(alu_op), 64'(a), "alu_op");
    check_val(64'(src1_pc), 64'd0, "src1_pc");
    check_val(64'(src2_sel), 64'(s2), "src2_sel");
    check_val(64'(gpr_wen), 64'(w), "gpr_wen");
    check_val(64'(mem_ren), 64'(mr), "mem_ren");
    check_val(64'(mem_wen), 64'(mw), "mem_wen");
    check_val(64'(mem_op), 64'(mo), "mem_op");
  endtask

  task automatic test_decode_read();
    logic [4:0] s1, s2, d;
    logic [11:0] i12;
    logic [19:0] i20;
    for (int r = 1; r < 32; r++) write_reg(5'(r), {lcg_next(), lcg_next()});
    write_reg(5'd0, 64'hdead_beef); // must be dropped
    for (int n = 0; n < 18; n++) begin
      s1 = (n == 1) ? 5'd0 : 5'(lcg_next() >> 8);
      s2 = 5'(lcg_next() >> 8);
      d = 5'd1 + 5'((lcg_next() >> 8) % 31);
      i12 = 12'(lcg_next() >> 4);
      i20 = 20'(lcg_next() >> 4);
      case (n % 6)
        0: begin
          send(enc_i(i12, s1, 3'b000, d, 7'b0010011), 64'h100 + 64'(n * 4));
          check_val(rs1data, reg_val(s1), "addi rs1data");
          check_val(imm, {{52{i12[11]}}, i12}, "addi imm");
          check_ctrl(3'd0, 1'b1, 1'b1, 1'b0, 1'b0, 2'd0);
        end
        1, 2: begin
          send(enc_r((n % 6 == 2) ? 7'h20 : 7'h00, s2, s1, 3'b000, d), 64'h100);
          check_val(rs1data, reg_val(s1), "op rs1data");
          check_val(rs2data, reg_val(s2), "op rs2data");
          check_ctrl((n % 6 == 2) ? 3'd1 : 3'd0, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0);
        end
        3: begin
          send({i20, d, 7'b0110111}, 64'h200);
          check_val(rs1data, 64'd0, "lui rs1data");
          check_val(imm, {{32{i20[19]}}, i20, 12'd0}, "lui imm");
          check_ctrl(3'd0, 1'b1, 1'b1, 1'b0, 1'b0, 2'd0);
        end
        4: begin
          send(enc_i(i12, s1, 3'b011, d, 7'b0000011), 64'h300);
          check_val(rs1data, reg_val(s1), "ld rs1data");
          check_val(imm, {{52{i12[11]}}, i12}, "ld imm");
          check_ctrl(3'd0, 1'b1, 1'b1, 1'b1, 1'b0, 2'd2);
        end
        default: begin
          send(enc_s(i12, s2, s1), 64'h400);
          check_val(rs1data, reg_val(s1), "sd rs1data");
          check_val(rs2data, reg_val(s2), "sd rs2data");
          check_val(imm, {{52{i12[11]}}, i12}, "sd imm");
          check_ctrl(3'd0, 1'b1, 1'b0, 1'b0, 1'b1, 2'd2);
        end
      endcase
      if (n % 6 != 5) check_val(64'(rd), 64'(d), "rd");
    end
  endtask

  task automatic test_forwarding();
    send(enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd1), 64'h500);
    @(negedge clk);
    es_rd = 5'd5;
    es_res = 64'haaaa;
    ms_rd = 5'd5;
    ms_res = 64'hbbbb;
    ws_rd = 5'd6;
    ws_res = 64'hcccc;
    #1;
    check_val(rs1data, 64'haaaa, "rs1 from execute");
    check_val(rs2data, 64'hcccc, "rs2 from writeback");
    @(negedge clk);
    es_rd = 5'd0;
    ms_rd = 5'd6;
    ws_rd = 5'd5;
    #1;
    check_val(rs1data, 64'hcccc, "rs1 from writeback");
    check_val(rs2data, 64'hbbbb, "rs2 from memory");
    @(negedge clk);
    ws_rd = 5'd6;
    #1;
    check_val(rs1data, model[5], "rs1 no match");
    check_val(rs2data, 64'hbbbb, "rs2 memory over writeback");
    @(negedge clk);
    ms_rd = 5'd9;
    ws_rd = 5'd0;
    #1;
    check_val(rs1data, model[5], "rs1 fallback");
    check_val(rs2data, model[6], "rs2 fallback");
    ms_rd = 5'd0;
  endtask

  task automatic check_branch(input logic [31:0] inst, input logic [63:0] pc,
                              input logic sel, input logic [63:0] target);
    send(inst, pc);
    check_val(64'(br_sel), 64'(sel), "br_sel");
    if (sel) check_val(br_target, target, "br_target");
    fs_pc = br_target;
    #1;
    check_val(64'(br_taken), 64'd0, "br_taken at target");
    fs_pc = br_target + 64'd4;
    #1;
    check_val(64'(br_taken), 64'(sel), "br_taken");
  endtask

  task automatic test_branches();
    logic [4:0] pa [6];
    logic [4:0] pb [6];
    logic [2:0] f3s [6];
    logic [12:0] bi;
    logic [20:0] ji;
    logic [11:0] ri;
    logic [63:0] sum;
    f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    pa = '{5'd11, 5'd14, 5'd13, 5'd11, 5'd11, 5'd13};
    pb = '{5'd12, 5'd11, 5'd11, 5'd13, 5'd13, 5'd11};
    write_reg(5'd11, 64'd5);
    write_reg(5'd12, 64'd5);
    write_reg(5'd13, -64'sd3);
    write_reg(5'd14, 64'd7);
    for (int k = 0; k < 6; k++) begin
      bi = {12'(lcg_next() >> 8), 1'b0};
      // listed pair holds and the swapped pair or x14 breaks it
      check_branch(enc_b(bi, pb[k], pa[k], f3s[k]), 64'h1000,
                   branch_holds(f3s[k], model[pa[k]], model[pb[k]]),
                   64'h1000 + {{51{bi[12]}}, bi});
      check_branch(enc_b(bi, 5'd14, pa[k], f3s[k]), 64'h2000,
                   branch_holds(f3s[k], model[pa[k]], model[14]),
                   64'h2000 + {{51{bi[12]}}, bi});
      check_branch(enc_b(bi, pa[k], pb[k], f3s[k]), 64'h3000,
                   branch_holds(f3s[k], model[pb[k]], model[pa[k]]),
                   64'h3000 + {{51{bi[12]}}, bi});
    end
    ji = {20'(lcg_next() >> 4), 1'b0};
    check_branch(enc_j(ji, 5'd1), 64'h4000, 1'b1, 64'h4000 + {{43{ji[20]}}, ji});
    check_val(64'(src1_pc), 64'd1, "jal src1_pc");
    ri = 12'(lcg_next() >> 8);
    sum = model[11] + {{52{ri[11]}}, ri};
    check_branch(enc_i(ri, 5'd11, 3'b000, 5'd1, 7'b1100111), 64'h5000, 1'b1,
                 {sum[63:1], 1'b0});
    check_val(64'(src1_pc), 64'd1, "jalr src1_pc");
    // wrong-path word behind a taken beq
    send(enc_b(13'h40, 5'd12, 5'd11, 3'b000), 64'h6000);
    fs_valid = 1'b1;
    fs_inst = enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd1);
    fs_pc = 64'h6004;
    @(negedge clk);
    fs_valid = 1'b0;
    #1;
    check_val(64'(ds_valid), 64'd1, "bubble valid");
    check_val(ds_pc, 64'd0, "bubble pc");
    check_val(64'(invalid), 64'd0, "bubble invalid");
    check_ctrl(3'd0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0);
  endtask

  task automatic test_backpressure();
    @(negedge clk);
    es_allowin = 1'b0;
    send(enc_i(12'h123, 5'd1, 3'b000, 5'd2, 7'b0010011), 64'h7000);
    fs_valid = 1'b1;
    fs_inst = enc_i(12'h456, 5'd1, 3'b000, 5'd3, 7'b0010011);
    fs_pc = 64'h7004;
    repeat (3) begin
      @(negedge clk);
      #1;
      check_val(64'(ds_allowin), 64'd0, "allowin under back-pressure");
      check_val(64'(ds_valid), 64'd1, "valid under back-pressure");
      check_val(ds_pc, 64'h7000, "held pc");
      check_val(imm, 64'h123, "held imm");
    end
    es_allowin = 1'b1;
    @(negedge clk);
    fs_valid = 1'b0;
    #1;
    check_val(ds_pc, 64'h7004, "next pc after release");
    check_val(imm, 64'h456, "next imm after release");
  endtask

  task automatic test_ebreak_invalid();
    int waited;
    @(negedge clk);
    ms_rd = `RV_REG_A0;
    send(32'h0010_0073, 64'h8000);
    repeat (3) begin
      check_val(64'(ds_valid), 64'd0, "ebreak held");
      @(negedge clk);
      #1;
    end
    ms_rd = 5'd0;
    #1;
    waited = 0;
    while (!ds_valid && waited < 10) begin
      @(negedge clk);
      #1;
      waited++;
    end
    check_val(64'(ds_valid), 64'd1, "ebreak released");
    check_val(64'(ebreak), 64'd1, "ebreak flag");
    send(32'h0000_007f, 64'h9000);
    check_val(64'(invalid), 64'd1, "bad opcode invalid");
    check_val(64'(gpr_wen), 64'd0, "bad opcode gpr_wen");
    send(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3), 64'h9004);
    check_val(64'(invalid), 64'd1, "bad funct7 invalid");
    check_val(64'(gpr_wen), 64'd0, "bad funct7 gpr_wen");
  endtask

  initial begin
    rst_n = 1'b0;
    es_allowin = 1'b1;
    fs_valid = 1'b0;
    fs_inst = '0;
    fs_pc = '0;
    ws_wen = 1'b0;
    ws_waddr = '0;
    ws_wdata = '0;
    es_rd = '0;
    ms_rd = '0;
    ws_rd = '0;
    es_res = '0;
    ms_res = '0;
    ws_res = '0;
    for (int r = 0; r < 32; r++) model[r] = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_val(64'(ds_valid), 64'd0, "valid after reset");
    check_val(64'(br_sel), 64'd0, "br_sel after reset");
    test_decode_read();
    test_forwarding();
    test_branches();
    test_backpressure();
    test_ebreak_invalid();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+design
design/rv_pkg.sv
design/id_decoder.sv
design/gpr_file.sv
design/operand_bypass.sv
design/branch_unit.sv
design/id_stage.sv
verif/id_stage_checker.sv
verif/id_stage_tb.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module id_stage_tb -o id_stage_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/id_stage_tb)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1
